// File: hw/mips_ctrl_pkg.sv
// MIPS control path definitions
// Opcodes, pc-source codes and per-stage control structs
package mips_ctrl_pkg;

  // Primary opcodes
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_J     = 6'b000010;
  localparam logic [5:0] OP_JAL   = 6'b000011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;
  localparam logic [5:0] OP_ADDI  = 6'b001000;
  localparam logic [5:0] OP_SLTI  = 6'b001010;
  localparam logic [5:0] OP_ANDI  = 6'b001100;
  localparam logic [5:0] OP_ORI   = 6'b001101;
  localparam logic [5:0] OP_XORI  = 6'b001110;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;

  // Function code of JR inside RTYPE
  localparam logic [5:0] FN_JR = 6'b001000;

  // Operation class for execute
  localparam logic [1:0] ALU_ADD   = 2'b00;
  localparam logic [1:0] ALU_FUNCT = 2'b10;

  // Destination register select
  localparam logic [1:0] DST_RT = 2'b00;
  localparam logic [1:0] DST_RD = 2'b01;
  localparam logic [1:0] DST_RA = 2'b10;

  localparam int unsigned      ADDR_W   = 32;
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

  typedef enum logic [1:0] {
    PC_SEQ    = 2'b00,
    PC_BRANCH = 2'b01,
    PC_JUMP   = 2'b10,
    PC_JR     = 2'b11
  } pc_src_t;

  typedef struct packed {
    logic rt_is_source;
    logic imm_command;
  } id_ctrl_t;

  typedef struct packed {
    logic       alu_src_b;
    logic       alu_rslt_src;
    logic [1:0] dst_reg_sel;
    logic [1:0] alu_op;
  } ex_ctrl_t;

  typedef struct packed {
    logic mem_read;
    logic mem_write;
  } mem_ctrl_t;

  typedef struct packed {
    logic mem_to_reg;
    logic reg_write;
  } wb_ctrl_t;

  // Stage payloads carry what the later stages still need
  typedef struct packed {
    ex_ctrl_t  ex;
    mem_ctrl_t mem;
    wb_ctrl_t  wb;
  } id_ex_t;

  typedef struct packed {
    mem_ctrl_t mem;
    wb_ctrl_t  wb;
  } ex_mem_t;

endpackage

// File: hw/control.sv
// Main instruction decoder
`timescale 1ns/1ps
module control
  import mips_ctrl_pkg::*;
(
  input  logic [31:0] instr,
  input  logic        branch_eq,
  output id_ctrl_t    id_ctrl,
  output ex_ctrl_t    ex_ctrl,
  output mem_ctrl_t   mem_ctrl,
  output wb_ctrl_t    wb_ctrl,
  output pc_src_t     pc_src
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    // Anything not listed below decodes to all zeros
    id_ctrl  = '0;
    ex_ctrl  = '0;
    mem_ctrl = '0;
    wb_ctrl  = '0;
    pc_src   = PC_SEQ;

    case (opcode)
      OP_LW: begin
        ex_ctrl.alu_src_b   = 1'b1;
        ex_ctrl.dst_reg_sel = DST_RT;
        ex_ctrl.alu_op      = ALU_ADD;
        mem_ctrl.mem_read   = 1'b1;
        wb_ctrl.mem_to_reg  = 1'b1;
        wb_ctrl.reg_write   = 1'b1;
      end
      OP_SW: begin
        ex_ctrl.alu_src_b    = 1'b1;
        ex_ctrl.alu_op       = ALU_ADD;
        mem_ctrl.mem_write   = 1'b1;
        wb_ctrl.mem_to_reg   = 1'b1;
        id_ctrl.rt_is_source = 1'b1;
      end
      OP_RTYPE: begin
        id_ctrl.rt_is_source = 1'b1;
        if (funct == FN_JR) begin
          pc_src = PC_JR;
        end else begin
          ex_ctrl.dst_reg_sel = DST_RD;
          ex_ctrl.alu_op      = ALU_FUNCT;
          wb_ctrl.reg_write   = 1'b1;
        end
      end
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI: begin
        ex_ctrl.alu_src_b   = 1'b1;
        ex_ctrl.alu_op      = ALU_FUNCT;
        wb_ctrl.reg_write   = 1'b1;
        id_ctrl.imm_command = 1'b1;
      end
      OP_BEQ: begin
        id_ctrl.rt_is_source = 1'b1;
        pc_src               = branch_eq ? PC_BRANCH : PC_SEQ;
      end
      OP_J: begin
        pc_src = PC_JUMP;
      end
      OP_JAL: begin
        // Link address goes to $ra through the result mux
        pc_src               = PC_JUMP;
        ex_ctrl.dst_reg_sel  = DST_RA;
        ex_ctrl.alu_rslt_src = 1'b1;
        wb_ctrl.reg_write    = 1'b1;
      end
      default: begin
        pc_src = PC_SEQ;
      end
    endcase
  end

endmodule

// File: hw/control_sva.sv
// Decoder control checker
`timescale 1ns/1ps
module control_sva
  import mips_ctrl_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic [5:0] opcode,
  input logic [5:0] special,
  input logic      branch_eq,
  input pc_src_t   pc_src,
  input id_ctrl_t  id_ctrl,
  input ex_ctrl_t  ex_ctrl,
  input mem_ctrl_t mem_ctrl,
  input wb_ctrl_t  wb_ctrl
);

  logic is_lw;
  logic is_sw;
  logic is_beq;
  logic is_rtype;
  logic is_jr;
  logic is_imm;
  logic is_jump;
  logic unrec_op;

  // Instruction classes re-derived from the raw fields
  assign is_lw    = (opcode == OP_LW);
  assign is_sw    = (opcode == OP_SW);
  assign is_beq   = (opcode == OP_BEQ);
  assign is_rtype = (opcode == OP_RTYPE) && (special != FN_JR);
  assign is_jr    = (opcode == OP_RTYPE) && (special == FN_JR);
  assign is_imm   = opcode inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI};
  assign is_jump  = (opcode == OP_J) || (opcode == OP_JAL);
  assign unrec_op = !(is_lw || is_sw || is_beq || is_rtype || is_jr || is_imm || is_jump);

  default clocking cb @(posedge clk);
  endclocking

  default disable iff (!rst_n);

  a_mem_excl: assert property (!(mem_ctrl.mem_read && mem_ctrl.mem_write))
    else $error("mem_read and mem_write both high");

  a_lw: assert property (is_lw |-> ex_ctrl == ex_ctrl_t'{1'b1, 1'b0, DST_RT, ALU_ADD} &&
                         mem_ctrl == mem_ctrl_t'{1'b1, 1'b0} &&
                         wb_ctrl == wb_ctrl_t'{1'b1, 1'b1} &&
                         id_ctrl == '0 && pc_src == PC_SEQ)
    else $error("LW controls mismatch");

  a_sw: assert property (is_sw |-> ex_ctrl == ex_ctrl_t'{1'b1, 1'b0, DST_RT, ALU_ADD} &&
                         mem_ctrl == mem_ctrl_t'{1'b0, 1'b1} &&
                         wb_ctrl == wb_ctrl_t'{1'b1, 1'b0} &&
                         id_ctrl == id_ctrl_t'{1'b1, 1'b0} && pc_src == PC_SEQ)
    else $error("SW controls mismatch");

  a_rtype: assert property (is_rtype |-> ex_ctrl == ex_ctrl_t'{1'b0, 1'b0, DST_RD, ALU_FUNCT} &&
                            mem_ctrl == '0 && wb_ctrl == wb_ctrl_t'{1'b0, 1'b1} &&
                            id_ctrl == id_ctrl_t'{1'b1, 1'b0} && pc_src == PC_SEQ)
    else $error("RTYPE controls mismatch");

  a_imm: assert property (is_imm |-> ex_ctrl == ex_ctrl_t'{1'b1, 1'b0, DST_RT, ALU_FUNCT} &&
                          mem_ctrl == '0 && wb_ctrl == wb_ctrl_t'{1'b0, 1'b1} &&
                          id_ctrl == id_ctrl_t'{1'b0, 1'b1} && pc_src == PC_SEQ)
    else $error("Immediate op controls mismatch");

  // Branch direction follows the comparison level of the same cycle
  a_beq: assert property (is_beq |-> ex_ctrl == '0 && mem_ctrl == '0 && wb_ctrl == '0 &&
                          id_ctrl == id_ctrl_t'{1'b1, 1'b0} &&
                          pc_src == (branch_eq ? PC_BRANCH : PC_SEQ))
    else $error("BEQ controls mismatch");

  a_j: assert property ((opcode == OP_J) |-> pc_src == PC_JUMP && ex_ctrl == '0 &&
                        mem_ctrl == '0 && wb_ctrl == '0 && id_ctrl == '0)
    else $error("J controls mismatch");

  a_jal: assert property ((opcode == OP_JAL) |->
                          ex_ctrl == ex_ctrl_t'{1'b0, 1'b1, DST_RA, ALU_ADD} &&
                          mem_ctrl == '0 && wb_ctrl == wb_ctrl_t'{1'b0, 1'b1} &&
                          id_ctrl == '0 && pc_src == PC_JUMP)
    else $error("JAL controls mismatch");

  a_jr: assert property (is_jr |-> pc_src == PC_JR && ex_ctrl == '0 && mem_ctrl == '0 &&
                         wb_ctrl == '0 && id_ctrl == id_ctrl_t'{1'b1, 1'b0})
    else $error("JR controls mismatch");

  a_unrec: assert property (unrec_op |-> pc_src == PC_SEQ && ex_ctrl == '0 &&
                            mem_ctrl == '0 && wb_ctrl == '0 && id_ctrl == '0)
    else $error("Unrecognized opcode has non-zero controls");

  // Every non-sequential pc choice traces back to its instruction
  a_src_br: assert property ((pc_src == PC_BRANCH) |-> is_beq && branch_eq)
    else $error("PC_BRANCH without taken BEQ");
  a_src_j: assert property ((pc_src == PC_JUMP) |-> is_jump)
    else $error("PC_JUMP without J or JAL");
  a_src_jr: assert property ((pc_src == PC_JR) |-> is_jr)
    else $error("PC_JR without JR");

  c_lw:     cover property (is_lw);
  c_sw:     cover property (is_sw);
  c_rtype:  cover property (is_rtype);
  c_jr:     cover property (is_jr);
  c_addi:   cover property (opcode == OP_ADDI);
  c_andi:   cover property (opcode == OP_ANDI);
  c_ori:    cover property (opcode == OP_ORI);
  c_xori:   cover property (opcode == OP_XORI);
  c_slti:   cover property (opcode == OP_SLTI);
  c_beq_t:  cover property (is_beq && branch_eq);
  c_beq_nt: cover property (is_beq && !branch_eq);
  c_j:      cover property (opcode == OP_J);
  c_jal:    cover property (opcode == OP_JAL);
  c_unrec:  cover property (unrec_op);
  c_seq:    cover property (pc_src == PC_SEQ);
  c_branch: cover property (pc_src == PC_BRANCH);
  c_jump:   cover property (pc_src == PC_JUMP);
  c_pc_jr:  cover property (pc_src == PC_JR);

endmodule

// File: hw/pipe_stage.sv
// Valid-tagged pipeline register
`timescale 1ns/1ps
module pipe_stage #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     valid_out,
  output payload_t data_out
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
      data_out  <= '0;
    end else begin
      valid_out <= valid_in;
      // Bubbles carry a zero payload
      data_out  <= valid_in ? data_in : '0;
    end
  end

  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(valid_out)
  ) else $error("valid_out unknown after reset");

endmodule

// File: hw/pc_select.sv
// Program counter and next-pc select
`timescale 1ns/1ps
module pc_select
  import mips_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              advance,
  input  logic [31:0]       instr,
  input  pc_src_t           pc_src,
  input  logic [ADDR_W-1:0] rs_value,
  output logic [ADDR_W-1:0] pc
);

  logic [ADDR_W-1:0] pc_plus4;
  logic [ADDR_W-1:0] br_offset;
  logic [ADDR_W-1:0] pc_next;

  assign pc_plus4  = pc + ADDR_W'(4);
  // Sign-extended word offset
  assign br_offset = {{(ADDR_W-18){instr[15]}}, instr[15:0], 2'b00};

  always_comb begin
    case (pc_src)
      PC_BRANCH: pc_next = pc_plus4 + br_offset;
      PC_JUMP:   pc_next = {pc_plus4[ADDR_W-1:ADDR_W-4], instr[25:0], 2'b00};
      PC_JR:     pc_next = rs_value;
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (advance) begin
      pc <= pc_next;
    end
  end

  // Only a misaligned JR target may break word alignment
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pc[1:0] == 2'b00) && !(advance && pc_src == PC_JR && rs_value[1:0] != 2'b00)
      |=> (pc[1:0] == 2'b00)
  ) else $error("pc lost word alignment");

endmodule

// File: hw/decode_top.sv
// Decode and control path top level
`timescale 1ns/1ps
module decode_top
  import mips_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [31:0]       instr,
  input  logic              instr_valid,
  input  logic              branch_eq,
  input  logic [ADDR_W-1:0] rs_value,
  output id_ctrl_t          id_ctrl,
  output id_ex_t            ex_out,
  output logic              ex_valid,
  output ex_mem_t           mem_out,
  output logic              mem_valid,
  output wb_ctrl_t          wb_out,
  output logic              wb_valid,
  output logic [ADDR_W-1:0] pc
);

  ex_ctrl_t  ex_ctrl;
  mem_ctrl_t mem_ctrl;
  wb_ctrl_t  wb_ctrl;
  pc_src_t   pc_src;
  id_ex_t    id_ex_in;
  ex_mem_t   ex_mem_in;

  control u_control (
    .instr, .branch_eq, .id_ctrl, .ex_ctrl, .mem_ctrl, .wb_ctrl, .pc_src
  );

  control_sva u_control_sva (
    .clk, .rst_n, .opcode(instr[31:26]), .special(instr[5:0]), .branch_eq,
    .pc_src, .id_ctrl, .ex_ctrl, .mem_ctrl, .wb_ctrl
  );

  // Each stage drops the fields its own stage consumed
  assign id_ex_in  = '{ex: ex_ctrl, mem: mem_ctrl, wb: wb_ctrl};
  assign ex_mem_in = '{mem: ex_out.mem, wb: ex_out.wb};

  pipe_stage #(.payload_t(id_ex_t)) u_id_ex (
    .clk, .rst_n, .valid_in(instr_valid), .data_in(id_ex_in),
    .valid_out(ex_valid), .data_out(ex_out)
  );

  pipe_stage #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk, .rst_n, .valid_in(ex_valid), .data_in(ex_mem_in),
    .valid_out(mem_valid), .data_out(mem_out)
  );

  pipe_stage #(.payload_t(wb_ctrl_t)) u_mem_wb (
    .clk, .rst_n, .valid_in(mem_valid), .data_in(mem_out.wb),
    .valid_out(wb_valid), .data_out(wb_out)
  );

  pc_select u_pc_select (
    .clk, .rst_n, .advance(instr_valid), .instr, .pc_src, .rs_value, .pc
  );

endmodule

// File: verif/control_tb.sv
// Decode and control path testbench
`timescale 1ns/1ps
module control_tb
  import mips_ctrl_pkg::*;
();

  localparam int NUM_VEC        = 25;
  localparam int RST_CYCLES     = 10;
  localparam int MAX_IDLE       = 4;
  localparam int DRAIN_CYCLES   = 4;
  localparam int BUBBLE_ID      = NUM_VEC + 1;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + NUM_VEC * (1 + MAX_IDLE) + DRAIN_CYCLES + 20;

  // Expected controls of one issue slot as it moves down the stages
  typedef struct packed {
    logic       valid;
    logic [7:0] test_id;
    id_ctrl_t   id;
    ex_ctrl_t   ex;
    mem_ctrl_t  mem;
    wb_ctrl_t   wb;
  } stage_exp_t;

  logic              clk;
  logic              rst_n;
  logic [31:0]       instr;
  logic              instr_valid;
  logic              branch_eq;
  logic [ADDR_W-1:0] rs_value;
  id_ctrl_t          id_ctrl;
  id_ex_t            ex_out;
  logic              ex_valid;
  ex_mem_t           mem_out;
  logic              mem_valid;
  wb_ctrl_t          wb_out;
  logic              wb_valid;
  logic [ADDR_W-1:0] pc;

  logic [119:0]      vectors [NUM_VEC];
  stage_exp_t        hist [3];
  logic [ADDR_W-1:0] exp_pc;
  int                pc_tid;
  int                test_errs [NUM_VEC + 2];
  int                err_count;
  int                tests_run;
  int                tests_failed;
  integer            seed;
  logic [31:0]       r;
  int                n_idle;

  decode_top DUT (
    .clk, .rst_n, .instr, .instr_valid, .branch_eq, .rs_value, .id_ctrl,
    .ex_out, .ex_valid, .mem_out, .mem_valid, .wb_out, .wb_valid, .pc
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic string test_name(input int tid);
    if (tid == 0) return "reset";
    else if (tid == BUBBLE_ID) return "bubbles";
    else return $sformatf("vec%0d", tid);
  endfunction

  task automatic check_value(input int tid, input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Error: %s %s expected %0h actual %0h", test_name(tid), what, expected, actual);
      test_errs[tid]++;
      err_count++;
    end
  endtask

  task automatic report_test(input int tid);
    tests_run++;
    if (test_errs[tid] == 0) begin
      $display("Test %s passed", test_name(tid));
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name(tid), test_errs[tid]);
    end
  endtask

  // Drive a vector or a bubble for one clock and check every stage
  task automatic run_cycle(input logic vld, input int vi);
    stage_exp_t   cur;
    logic [119:0] v;
    int           tid;
    @(posedge clk);
    #1;
    cur = '0;
    v   = vectors[vi];
    if (vld) begin
      instr        = v[119:88];
      branch_eq    = v[84];
      rs_value     = v[83:52];
      instr_valid  = 1'b1;
      cur.valid    = 1'b1;
      cur.test_id  = 8'(vi + 1);
      cur.id       = v[49:48];
      cur.ex       = v[45:40];
      cur.mem      = v[37:36];
      cur.wb       = v[33:32];
    end else begin
      // Idle slots carry junk that must be ignored
      instr       = $random(seed);
      branch_eq   = 1'b0;
      rs_value    = '0;
      instr_valid = 1'b0;
    end
    #2;
    if (vld) check_value(vi + 1, "id_ctrl", cur.id, id_ctrl);
    check_value(pc_tid, "pc", exp_pc, pc);
    tid = hist[0].valid ? int'(hist[0].test_id) : BUBBLE_ID;
    check_value(tid, "ex_valid", hist[0].valid, ex_valid);
    check_value(tid, "ex_out", {hist[0].ex, hist[0].mem, hist[0].wb}, ex_out);
    tid = hist[1].valid ? int'(hist[1].test_id) : BUBBLE_ID;
    check_value(tid, "mem_valid", hist[1].valid, mem_valid);
    check_value(tid, "mem_out", {hist[1].mem, hist[1].wb}, mem_out);
    tid = hist[2].valid ? int'(hist[2].test_id) : BUBBLE_ID;
    check_value(tid, "wb_valid", hist[2].valid, wb_valid);
    check_value(tid, "wb_out", hist[2].wb, wb_out);
    if (hist[2].valid) report_test(tid);
    hist[2] = hist[1];
    hist[1] = hist[0];
    hist[0] = cur;
    if (vld) begin
      exp_pc = v[31:0];
      pc_tid = vi + 1;
    end else begin
      pc_tid = BUBBLE_ID;
    end
  endtask

  initial begin
    seed         = 81515;
    rst_n        = 1'b0;
    instr        = '0;
    instr_valid  = 1'b0;
    branch_eq    = 1'b0;
    rs_value     = '0;
    exp_pc       = RESET_PC;
    pc_tid       = BUBBLE_ID;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    foreach (test_errs[i]) test_errs[i] = 0;
    foreach (hist[i]) hist[i] = '0;
    $readmemh("verif/control_input.txt", vectors);
    if ($isunknown(vectors[0]) || $isunknown(vectors[NUM_VEC-1])) begin
      $display("The vector file verif/control_input.txt is missing or has too few lines");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      check_value(0, "ex_valid", 1'b0, ex_valid);
      check_value(0, "mem_valid", 1'b0, mem_valid);
      check_value(0, "wb_valid", 1'b0, wb_valid);
      check_value(0, "ex_out", '0, ex_out);
      check_value(0, "mem_out", '0, mem_out);
      check_value(0, "wb_out", '0, wb_out);
      check_value(0, "pc", RESET_PC, pc);
      report_test(0);
      rst_n = 1'b1;
      for (int vi = 0; vi < NUM_VEC; vi++) begin
        run_cycle(1'b1, vi);
        r      = $random(seed);
        n_idle = (r[1:0] == 2'd0) ? int'(r[3:2]) + 1 : 0;
        repeat (n_idle) run_cycle(1'b0, 0);
      end
      repeat (DRAIN_CYCLES) run_cycle(1'b0, 0);
      report_test(BUBBLE_ID);
      $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: verif/control_input.txt
// instr _ branch_eq _ rs_value _ id_ctrl _ ex_ctrl _ mem_ctrl _ wb_ctrl _ pc after instr
// id {rt_is_source,imm_command}, ex {alu_src_b,alu_rslt_src,dst,alu_op}
// mem {mem_read,mem_write}, wb {mem_to_reg,reg_write}
8D090004_0_00000000_0_20_2_3_00000004
AD090008_0_00000000_2_20_1_2_00000008
01095020_0_00000000_2_06_0_1_0000000C
210B0005_0_00000000_1_22_0_1_00000010
310B00FF_0_00000000_1_22_0_1_00000014
350B0F0F_0_00000000_1_22_0_1_00000018
390B1234_0_00000000_1_22_0_1_0000001C
290B0010_0_00000000_1_22_0_1_00000020
11090004_0_00000000_2_00_0_0_00000024
11090003_1_00000000_2_00_0_0_00000034
1109FFFE_1_00000000_2_00_0_0_00000030
08000100_0_00000000_0_00_0_0_00000400
0C000200_0_00000000_0_18_0_1_00000800
03E00008_0_00001000_2_00_0_0_00001000
FC000000_0_00000000_0_00_0_0_00001004
04000000_1_00000000_0_00_0_0_00001008
01095022_0_00000000_2_06_0_1_0000100C
03E00008_0_80000040_2_00_0_0_80000040
08000020_0_00000000_0_00_0_0_80000080
8D090004_0_12345678_0_20_2_3_80000084
210B0005_1_00000000_1_22_0_1_80000088
1109FFFE_0_00000000_2_00_0_0_8000008C
0C000004_0_00000000_0_18_0_1_80000010
AD090008_0_00000000_2_20_1_2_80000014
01095025_0_00000000_2_06_0_1_80000018

// File: list.f
hw/mips_ctrl_pkg.sv
hw/control.sv
hw/control_sva.sv
hw/pipe_stage.sv
hw/pc_select.sv
hw/decode_top.sv
verif/control_tb.sv
